//--- Bender.yml
package:
  name: id_stage

sources:
  - hdl/isa_pkg.sv
  - hdl/pipe_pkg.sv
  - hdl/if_id_reg.sv
  - hdl/regfile.sv
  - hdl/operand_bypass.sv
  - hdl/inst_decoder.sv
  - hdl/branch_unit.sv
  - hdl/id_stage.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/id_stage_tb.sv

//--- dv/id_model.svh
// decoded instruction classes
typedef enum {
    k_none, k_alu_rr, k_shift_sa, k_jr, k_jalr, k_imm_sext, k_imm_zext,
    k_load, k_store, k_beq, k_bne, k_j, k_jal
} inst_kind_t;

isa_pkg::word_t      ref_regs [32];
pipe_pkg::if_to_id_t ref_held;

// ************************************************************
// instruction classes and alu operation
// ************************************************************
function automatic inst_kind_t classify_inst(input isa_pkg::inst_t inst);
    if (inst.r.opcode == isa_pkg::op_special) begin
        case (inst.r.funct)
            isa_pkg::fn_sll, isa_pkg::fn_srl, isa_pkg::fn_sra: return k_shift_sa;
            isa_pkg::fn_jr: return k_jr;
            isa_pkg::fn_jalr: return k_jalr;
            isa_pkg::fn_sllv, isa_pkg::fn_srlv, isa_pkg::fn_srav,
            isa_pkg::fn_add, isa_pkg::fn_addu, isa_pkg::fn_sub, isa_pkg::fn_subu,
            isa_pkg::fn_slt, isa_pkg::fn_sltu, isa_pkg::fn_and, isa_pkg::fn_or,
            isa_pkg::fn_xor, isa_pkg::fn_nor: return k_alu_rr;
            default: return k_none;
        endcase
    end
    case (inst.i.opcode)
        isa_pkg::op_addi, isa_pkg::op_addiu, isa_pkg::op_slti, isa_pkg::op_sltiu,
        isa_pkg::op_lui: return k_imm_sext;
        isa_pkg::op_andi, isa_pkg::op_ori, isa_pkg::op_xori: return k_imm_zext;
        isa_pkg::op_lb, isa_pkg::op_lbu, isa_pkg::op_lh, isa_pkg::op_lhu,
        isa_pkg::op_lw: return k_load;
        isa_pkg::op_sb, isa_pkg::op_sh, isa_pkg::op_sw: return k_store;
        isa_pkg::op_beq: return k_beq;
        isa_pkg::op_bne: return k_bne;
        isa_pkg::op_j: return k_j;
        isa_pkg::op_jal: return k_jal;
        default: return k_none;
    endcase
endfunction

function automatic pipe_pkg::alu_op_t expected_alu_op(input isa_pkg::inst_t inst);
    pipe_pkg::alu_op_t a;
    a = '0;
    if (inst.r.opcode == isa_pkg::op_special) begin
        case (inst.r.funct)
            isa_pkg::fn_add, isa_pkg::fn_addu: a.op_add = 1'b1;
            isa_pkg::fn_sub, isa_pkg::fn_subu: a.op_sub = 1'b1;
            isa_pkg::fn_slt: a.op_slt = 1'b1;
            isa_pkg::fn_sltu: a.op_sltu = 1'b1;
            isa_pkg::fn_and: a.op_and = 1'b1;
            isa_pkg::fn_or: a.op_or = 1'b1;
            isa_pkg::fn_xor: a.op_xor = 1'b1;
            isa_pkg::fn_nor: a.op_nor = 1'b1;
            isa_pkg::fn_sll, isa_pkg::fn_sllv: a.op_sll = 1'b1;
            isa_pkg::fn_srl, isa_pkg::fn_srlv: a.op_srl = 1'b1;
            isa_pkg::fn_sra, isa_pkg::fn_srav: a.op_sra = 1'b1;
            default: ;
        endcase
    end else begin
        // memory access computes its address in the adder
        case (inst.i.opcode)
            isa_pkg::op_addi, isa_pkg::op_addiu, isa_pkg::op_lb, isa_pkg::op_lbu,
            isa_pkg::op_lh, isa_pkg::op_lhu, isa_pkg::op_lw, isa_pkg::op_sb,
            isa_pkg::op_sh, isa_pkg::op_sw: a.op_add = 1'b1;
            isa_pkg::op_slti: a.op_slt = 1'b1;
            isa_pkg::op_sltiu: a.op_sltu = 1'b1;
            isa_pkg::op_andi: a.op_and = 1'b1;
            isa_pkg::op_ori: a.op_or = 1'b1;
            isa_pkg::op_xori: a.op_xor = 1'b1;
            isa_pkg::op_lui: a.op_lui = 1'b1;
            default: ;
        endcase
    end
    return a;
endfunction

// ************************************************************
// operands, control word and branch result
// ************************************************************
function automatic isa_pkg::word_t forwarded_operand(
    input isa_pkg::reg_addr_t  addr,
    input pipe_pkg::rf_write_t ex,
    input pipe_pkg::rf_write_t mem
);
    if (addr != 5'd0 && ex.we && ex.waddr == addr) begin
        return ex.wdata;
    end
    if (addr != 5'd0 && mem.we && mem.waddr == addr) begin
        return mem.wdata;
    end
    return ref_regs[addr];
endfunction

function automatic pipe_pkg::id_to_ex_t expected_id_to_ex(
    input pipe_pkg::if_to_id_t held,
    input isa_pkg::inst_t      inst,
    input isa_pkg::word_t      rs_val,
    input isa_pkg::word_t      rt_val
);
    pipe_pkg::id_to_ex_t e;
    inst_kind_t          k;
    logic                writes_rd;
    logic                writes_rt;
    k = held.ce ? classify_inst(inst) : k_none;
    e = '0;
    e.pc      = held.pc;
    e.inst    = inst;
    e.rs_data = rs_val;
    e.rt_data = rt_val;
    if (held.ce) begin
        e.alu_op = expected_alu_op(inst);
    end
    writes_rd = (k == k_alu_rr) || (k == k_shift_sa) || (k == k_jalr);
    writes_rt = (k == k_imm_sext) || (k == k_imm_zext) || (k == k_load);
    e.src1_sel.sa = (k == k_shift_sa);
    e.src1_sel.rs = writes_rt || (k == k_alu_rr) || (k == k_store) || (k == k_beq)
                  || (k == k_bne) || (k == k_jr) || (k == k_jalr);
    e.src2_sel.rt       = (k == k_alu_rr) || (k == k_shift_sa) || (k == k_beq) || (k == k_bne);
    e.src2_sel.imm_sext = (k == k_imm_sext) || (k == k_load) || (k == k_store);
    e.src2_sel.imm_zext = (k == k_imm_zext);
    e.mem_en = (k == k_load) || (k == k_store);
    if (k == k_store) begin
        case (inst.i.opcode)
            isa_pkg::op_sb: e.mem_wen = 4'd1;
            isa_pkg::op_sh: e.mem_wen = 4'd3;
            default: e.mem_wen = 4'd15;
        endcase
    end
    e.rf_we = writes_rd || writes_rt || (k == k_jal);
    if (writes_rd) begin
        e.rf_waddr = inst.r.rd;
    end else if (writes_rt) begin
        e.rf_waddr = inst.i.rt;
    end else if (k == k_jal) begin
        e.rf_waddr = 5'd31;
    end
    if (k == k_load) begin
        e.res_sel = pipe_pkg::res_load;
    end else if (k == k_jal || k == k_jalr) begin
        e.res_sel = pipe_pkg::res_link;
    end
    return e;
endfunction

function automatic pipe_pkg::br_t expected_br(
    input pipe_pkg::if_to_id_t held,
    input isa_pkg::inst_t      inst,
    input isa_pkg::word_t      rs_val,
    input isa_pkg::word_t      rt_val
);
    pipe_pkg::br_t  b;
    inst_kind_t     k;
    isa_pkg::word_t next_pc;
    k = held.ce ? classify_inst(inst) : k_none;
    next_pc = held.pc + 32'd4;
    b = '0;
    case (k)
        k_beq, k_bne: begin
            b.taken  = (k == k_beq) ? (rs_val == rt_val) : (rs_val != rt_val);
            b.target = next_pc + {{14{inst.i.imm[15]}}, inst.i.imm, 2'b00};
        end
        k_j, k_jal: begin
            b.taken  = 1'b1;
            b.target = {next_pc[31:28], inst.j.index, 2'b00};
        end
        k_jr, k_jalr: begin
            b.taken  = 1'b1;
            b.target = rs_val;
        end
        default: ;
    endcase
    return b;
endfunction

// state update at a clock edge
task automatic advance_state(
    input logic                rst_now,
    input pipe_pkg::stall_t    st,
    input pipe_pkg::if_to_id_t fetched,
    input pipe_pkg::rf_write_t wb
);
    if (rst_now) begin
        ref_held = '0;
        for (int k = 0; k < 32; k++) begin
            ref_regs[k] = '0;
        end
    end else begin
        // fetch stopped but decode free, so a bubble enters
        if (st[pipe_pkg::stall_if] && !st[pipe_pkg::stall_id]) begin
            ref_held = '0;
        end else if (!st[pipe_pkg::stall_if]) begin
            ref_held = fetched;
        end
        if (wb.we && wb.waddr != 5'd0) begin
            ref_regs[wb.waddr] = wb.wdata;
        end
    end
endtask

//--- dv/id_stage_tb.sv
module id_stage_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int reset_cycles   = 3;
    localparam int num_cycles     = 4000;
    localparam int timeout_cycles = num_cycles + num_cycles / 4;

    logic                clk;
    logic                rst;
    pipe_pkg::stall_t    stall;
    pipe_pkg::if_to_id_t if_to_id;
    isa_pkg::word_t      inst_sram_rdata;
    pipe_pkg::rf_write_t wb_to_rf;
    pipe_pkg::rf_write_t ex_to_id;
    pipe_pkg::rf_write_t mem_to_id;
    pipe_pkg::id_to_ex_t id_to_ex;
    pipe_pkg::br_t       br;

    integer seed;
    int     cycles;

`include "id_model.svh"

    id_stage dut (
        .clk             (clk),
        .rst             (rst),
        .stall           (stall),
        .if_to_id        (if_to_id),
        .inst_sram_rdata (inst_sram_rdata),
        .wb_to_rf        (wb_to_rf),
        .ex_to_id        (ex_to_id),
        .mem_to_id       (mem_to_id),
        .id_to_ex        (id_to_ex),
        .br              (br)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > timeout_cycles) begin
            abort_run("timeout, the test did not finish in time");
        end
    end

    // ************************************************************
    // random stimulus
    // ************************************************************
    function automatic int unsigned pick_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic isa_pkg::inst_t random_inst();
        isa_pkg::inst_t   w;
        isa_pkg::opcode_t op;
        isa_pkg::funct_t  fn;
        w = isa_pkg::inst_t'($random(seed));
        // few registers, so writes and forwards hit the reads
        w.r.rs = isa_pkg::reg_addr_t'(pick_below(8));
        w.r.rt = isa_pkg::reg_addr_t'(pick_below(8));
        w.r.rd = isa_pkg::reg_addr_t'(pick_below(8));
        op = op.first();
        fn = fn.first();
        repeat (pick_below(op.num())) begin
            op = op.next();
        end
        repeat (pick_below(fn.num())) begin
            fn = fn.next();
        end
        case (pick_below(8))
            0, 1, 2: begin
                w.r.opcode = isa_pkg::op_special;
                w.r.funct  = fn;
            end
            7: ;
            default: w.r.opcode = op;
        endcase
        return w;
    endfunction

    function automatic pipe_pkg::rf_write_t random_write(input int unsigned one_in);
        pipe_pkg::rf_write_t w;
        w.we    = (pick_below(one_in) == 0);
        w.waddr = isa_pkg::reg_addr_t'(pick_below(8));
        w.wdata = $random(seed);
        return w;
    endfunction

    task automatic drive_random();
        stall           <= (pick_below(8) == 0) ? pipe_pkg::stall_t'($random(seed)) : '0;
        if_to_id.ce     <= (pick_below(4) != 0);
        if_to_id.pc     <= $random(seed);
        inst_sram_rdata <= random_inst();
        wb_to_rf        <= random_write(2);
        ex_to_id        <= random_write(3);
        mem_to_id       <= random_write(3);
    endtask

    // ************************************************************
    // checks
    // ************************************************************
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_id_to_ex(
        input string               name,
        input pipe_pkg::id_to_ex_t exp,
        input pipe_pkg::id_to_ex_t act
    );
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s id_to_ex: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_br(input string name, input pipe_pkg::br_t exp, input pipe_pkg::br_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s br: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_outputs(input string name);
        isa_pkg::inst_t inst;
        isa_pkg::word_t rs_val;
        isa_pkg::word_t rt_val;
        inst   = inst_sram_rdata;
        rs_val = forwarded_operand(inst.r.rs, ex_to_id, mem_to_id);
        rt_val = forwarded_operand(inst.r.rt, ex_to_id, mem_to_id);
        check_id_to_ex(name, expected_id_to_ex(ref_held, inst, rs_val, rt_val), id_to_ex);
        check_br(name, expected_br(ref_held, inst, rs_val, rt_val), br);
    endtask

    initial begin
        string name;
        seed            = 32'h50107fcc;
        cycles          = 0;
        clk             = 1'b0;
        rst             = 1'b1;
        stall           = '0;
        if_to_id        = '0;
        inst_sram_rdata = '0;
        wb_to_rf        = '0;
        ex_to_id        = '0;
        mem_to_id       = '0;
        for (int c = 0; c < reset_cycles + num_cycles; c++) begin
            @(posedge clk);
            advance_state(rst, stall, if_to_id, wb_to_rf);
            if (c == reset_cycles - 1) begin
                rst <= 1'b0;
            end
            if (c >= reset_cycles - 1) begin
                drive_random();
            end
            // combinational outputs settle by the falling edge
            @(negedge clk);
            name = (c < reset_cycles) ? "reset" : $sformatf("random cycle %0d", c - reset_cycles);
            check_outputs(name);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- hdl/branch_unit.sv
module branch_unit (
    input  isa_pkg::word_t     pc,
    input  isa_pkg::inst_t     inst,
    input  isa_pkg::word_t     rs_data,
    input  isa_pkg::word_t     rt_data,
    input  pipe_pkg::br_kind_t br_kind,
    output pipe_pkg::br_t      br
);

    isa_pkg::word_t pc_plus_4;
    isa_pkg::word_t br_offset;
    logic           rs_eq_rt;
    logic           cond_branch;
    logic           region_jump;
    logic           reg_jump;

    assign pc_plus_4 = pc + isa_pkg::word_t'(4);

    // sign-extended word offset
    assign br_offset = {{14{inst.i.imm[15]}}, inst.i.imm, 2'b00};

    // operands arrive already forwarded
    assign rs_eq_rt = (rs_data == rt_data);

    assign cond_branch = br_kind.beq | br_kind.bne;
    assign region_jump = br_kind.j | br_kind.jal;
    assign reg_jump    = br_kind.jr | br_kind.jalr;

    always_comb begin
        br.taken = (br_kind.beq && rs_eq_rt)
                || (br_kind.bne && !rs_eq_rt)
                || region_jump
                || reg_jump;

        if (cond_branch) begin
            br.target = pc_plus_4 + br_offset;
        end else if (region_jump) begin
            // stays inside the 256 MB region of the delay slot
            br.target = {pc_plus_4[31:28], inst.j.index, 2'b00};
        end else if (reg_jump) begin
            br.target = rs_data;
        end else begin
            br.target = '0;
        end
    end

endmodule

//--- hdl/id_stage.sv
module id_stage (
    input  logic                clk,
    input  logic                rst,
    input  pipe_pkg::stall_t    stall,
    input  pipe_pkg::if_to_id_t if_to_id,
    input  isa_pkg::word_t      inst_sram_rdata,
    input  pipe_pkg::rf_write_t wb_to_rf,
    input  pipe_pkg::rf_write_t ex_to_id,
    input  pipe_pkg::rf_write_t mem_to_id,
    output pipe_pkg::id_to_ex_t id_to_ex,
    output pipe_pkg::br_t       br
);

    pipe_pkg::if_to_id_t held;
    isa_pkg::inst_t      inst;
    isa_pkg::word_t      rf_rdata1;
    isa_pkg::word_t      rf_rdata2;
    isa_pkg::word_t      rs_data;
    isa_pkg::word_t      rt_data;
    pipe_pkg::br_kind_t  br_kind;

    // sram returns the word for the held pc
    assign inst = inst_sram_rdata;

    if_id_reg u_if_id_reg (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .if_to_id (if_to_id),
        .held     (held)
    );

    regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (inst.r.rs),
        .raddr2 (inst.r.rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (wb_to_rf)
    );

    operand_bypass u_operand_bypass (
        .raddr1    (inst.r.rs),
        .raddr2    (inst.r.rt),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .ex_fwd    (ex_to_id),
        .mem_fwd   (mem_to_id),
        .rs_data   (rs_data),
        .rt_data   (rt_data)
    );

    inst_decoder u_inst_decoder (
        .ce       (held.ce),
        .pc       (held.pc),
        .inst     (inst),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .id_to_ex (id_to_ex),
        .br_kind  (br_kind)
    );

    branch_unit u_branch_unit (
        .pc      (held.pc),
        .inst    (inst),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .br_kind (br_kind),
        .br      (br)
    );

endmodule

//--- hdl/if_id_reg.sv
module if_id_reg (
    input  logic                clk,
    input  logic                rst,
    input  pipe_pkg::stall_t    stall,
    input  pipe_pkg::if_to_id_t if_to_id,
    output pipe_pkg::if_to_id_t held
);

    logic load_bubble;
    logic load_next;

    // fetch stopped while decode runs on, so decode sees a bubble
    assign load_bubble = stall[pipe_pkg::stall_if] && !stall[pipe_pkg::stall_id];
    assign load_next   = !stall[pipe_pkg::stall_if];

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= '0;
        end else if (load_bubble) begin
            held <= '0;
        end else if (load_next) begin
            held <= if_to_id;
        end
    end

endmodule

//--- hdl/inst_decoder.sv
module inst_decoder (
    input  logic                ce,
    input  isa_pkg::word_t      pc,
    input  isa_pkg::inst_t      inst,
    input  isa_pkg::word_t      rs_data,
    input  isa_pkg::word_t      rt_data,
    output pipe_pkg::id_to_ex_t id_to_ex,
    output pipe_pkg::br_kind_t  br_kind
);

    logic special;
    logic is_add, is_addu, is_sub, is_subu, is_slt, is_sltu;
    logic is_and, is_or, is_xor, is_nor;
    logic is_sll, is_srl, is_sra, is_sllv, is_srlv, is_srav;
    logic is_jr, is_jalr;
    logic is_addi, is_addiu, is_slti, is_sltiu;
    logic is_andi, is_ori, is_xori, is_lui;
    logic is_lb, is_lbu, is_lh, is_lhu, is_lw, is_sb, is_sh, is_sw;
    logic is_beq, is_bne, is_j, is_jal;
    logic alu_rr, shift_sa, alu_r, imm_sext, imm_zext, load, store;

    // ************************************************************
    // recognition, all terms gated by ce
    // ************************************************************
    assign special  = ce && (inst.r.opcode == isa_pkg::op_special);

    assign is_add   = special && (inst.r.funct == isa_pkg::fn_add);
    assign is_addu  = special && (inst.r.funct == isa_pkg::fn_addu);
    assign is_sub   = special && (inst.r.funct == isa_pkg::fn_sub);
    assign is_subu  = special && (inst.r.funct == isa_pkg::fn_subu);
    assign is_slt   = special && (inst.r.funct == isa_pkg::fn_slt);
    assign is_sltu  = special && (inst.r.funct == isa_pkg::fn_sltu);
    assign is_and   = special && (inst.r.funct == isa_pkg::fn_and);
    assign is_or    = special && (inst.r.funct == isa_pkg::fn_or);
    assign is_xor   = special && (inst.r.funct == isa_pkg::fn_xor);
    assign is_nor   = special && (inst.r.funct == isa_pkg::fn_nor);
    assign is_sll   = special && (inst.r.funct == isa_pkg::fn_sll);
    assign is_srl   = special && (inst.r.funct == isa_pkg::fn_srl);
    assign is_sra   = special && (inst.r.funct == isa_pkg::fn_sra);
    assign is_sllv  = special && (inst.r.funct == isa_pkg::fn_sllv);
    assign is_srlv  = special && (inst.r.funct == isa_pkg::fn_srlv);
    assign is_srav  = special && (inst.r.funct == isa_pkg::fn_srav);
    assign is_jr    = special && (inst.r.funct == isa_pkg::fn_jr);
    assign is_jalr  = special && (inst.r.funct == isa_pkg::fn_jalr);

    assign is_addi  = ce && (inst.i.opcode == isa_pkg::op_addi);
    assign is_addiu = ce && (inst.i.opcode == isa_pkg::op_addiu);
    assign is_slti  = ce && (inst.i.opcode == isa_pkg::op_slti);
    assign is_sltiu = ce && (inst.i.opcode == isa_pkg::op_sltiu);
    assign is_andi  = ce && (inst.i.opcode == isa_pkg::op_andi);
    assign is_ori   = ce && (inst.i.opcode == isa_pkg::op_ori);
    assign is_xori  = ce && (inst.i.opcode == isa_pkg::op_xori);
    assign is_lui   = ce && (inst.i.opcode == isa_pkg::op_lui);
    assign is_lb    = ce && (inst.i.opcode == isa_pkg::op_lb);
    assign is_lbu   = ce && (inst.i.opcode == isa_pkg::op_lbu);
    assign is_lh    = ce && (inst.i.opcode == isa_pkg::op_lh);
    assign is_lhu   = ce && (inst.i.opcode == isa_pkg::op_lhu);
    assign is_lw    = ce && (inst.i.opcode == isa_pkg::op_lw);
    assign is_sb    = ce && (inst.i.opcode == isa_pkg::op_sb);
    assign is_sh    = ce && (inst.i.opcode == isa_pkg::op_sh);
    assign is_sw    = ce && (inst.i.opcode == isa_pkg::op_sw);
    assign is_beq   = ce && (inst.i.opcode == isa_pkg::op_beq);
    assign is_bne   = ce && (inst.i.opcode == isa_pkg::op_bne);
    assign is_j     = ce && (inst.j.opcode == isa_pkg::op_j);
    assign is_jal   = ce && (inst.j.opcode == isa_pkg::op_jal);

    // instruction classes
    assign alu_rr   = is_add | is_addu | is_sub | is_subu | is_slt | is_sltu
                    | is_and | is_or | is_xor | is_nor | is_sllv | is_srlv | is_srav;
    assign shift_sa = is_sll | is_srl | is_sra;
    assign alu_r    = alu_rr | shift_sa;
    assign imm_sext = is_addi | is_addiu | is_slti | is_sltiu | is_lui;
    assign imm_zext = is_andi | is_ori | is_xori;
    assign load     = is_lb | is_lbu | is_lh | is_lhu | is_lw;
    assign store    = is_sb | is_sh | is_sw;

    // ************************************************************
    // control word
    // ************************************************************
    always_comb begin
        id_to_ex = '0;
        id_to_ex.pc      = pc;
        id_to_ex.inst    = inst;
        id_to_ex.rs_data = rs_data;
        id_to_ex.rt_data = rt_data;

        // loads and stores use the adder for the address
        id_to_ex.alu_op.op_add  = is_add | is_addu | is_addi | is_addiu | load | store;
        id_to_ex.alu_op.op_sub  = is_sub | is_subu;
        id_to_ex.alu_op.op_slt  = is_slt | is_slti;
        id_to_ex.alu_op.op_sltu = is_sltu | is_sltiu;
        id_to_ex.alu_op.op_and  = is_and | is_andi;
        id_to_ex.alu_op.op_nor  = is_nor;
        id_to_ex.alu_op.op_or   = is_or | is_ori;
        id_to_ex.alu_op.op_xor  = is_xor | is_xori;
        id_to_ex.alu_op.op_sll  = is_sll | is_sllv;
        id_to_ex.alu_op.op_srl  = is_srl | is_srlv;
        id_to_ex.alu_op.op_sra  = is_sra | is_srav;
        id_to_ex.alu_op.op_lui  = is_lui;

        id_to_ex.src1_sel.sa = shift_sa;
        id_to_ex.src1_sel.rs = alu_rr | imm_sext | imm_zext | load | store
                             | is_beq | is_bne | is_jr | is_jalr;

        id_to_ex.src2_sel.rt       = alu_r | is_beq | is_bne;
        id_to_ex.src2_sel.imm_sext = imm_sext | load | store;
        id_to_ex.src2_sel.imm_zext = imm_zext;

        id_to_ex.mem_en = load | store;
        if (is_sw) begin
            id_to_ex.mem_wen = 4'b1111;
        end else if (is_sh) begin
            id_to_ex.mem_wen = 4'b0011;
        end else if (is_sb) begin
            id_to_ex.mem_wen = 4'b0001;
        end

        id_to_ex.rf_we = alu_r | imm_sext | imm_zext | load | is_jal | is_jalr;
        if (alu_r || is_jalr) begin
            id_to_ex.rf_waddr = inst.r.rd;
        end else if (imm_sext || imm_zext || load) begin
            id_to_ex.rf_waddr = inst.i.rt;
        end else if (is_jal) begin
            id_to_ex.rf_waddr = isa_pkg::regimm_link;
        end

        // link writes pc+8, selected in EX
        if (load) begin
            id_to_ex.res_sel = pipe_pkg::res_load;
        end else if (is_jal || is_jalr) begin
            id_to_ex.res_sel = pipe_pkg::res_link;
        end else begin
            id_to_ex.res_sel = pipe_pkg::res_alu;
        end
    end

    assign br_kind.beq  = is_beq;
    assign br_kind.bne  = is_bne;
    assign br_kind.j    = is_j;
    assign br_kind.jal  = is_jal;
    assign br_kind.jr   = is_jr;
    assign br_kind.jalr = is_jalr;

endmodule

//--- hdl/isa_pkg.sv
package isa_pkg;

    localparam int unsigned xlen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // link target of jal
    localparam reg_addr_t regimm_link = 5'd31;

    // ************************************************************
    // primary opcodes
    // ************************************************************
    typedef enum logic [5:0] {
        op_special = 6'b00_0000,
        op_j       = 6'b00_0010,
        op_jal     = 6'b00_0011,
        op_beq     = 6'b00_0100,
        op_bne     = 6'b00_0101,
        op_addi    = 6'b00_1000,
        op_addiu   = 6'b00_1001,
        op_slti    = 6'b00_1010,
        op_sltiu   = 6'b00_1011,
        op_andi    = 6'b00_1100,
        op_ori     = 6'b00_1101,
        op_xori    = 6'b00_1110,
        op_lui     = 6'b00_1111,
        op_lb      = 6'b10_0000,
        op_lh      = 6'b10_0001,
        op_lw      = 6'b10_0011,
        op_lbu     = 6'b10_0100,
        op_lhu     = 6'b10_0101,
        op_sb      = 6'b10_1000,
        op_sh      = 6'b10_1001,
        op_sw      = 6'b10_1011
    } opcode_t;

    // function field under op_special
    typedef enum logic [5:0] {
        fn_sll  = 6'b00_0000,
        fn_srl  = 6'b00_0010,
        fn_sra  = 6'b00_0011,
        fn_sllv = 6'b00_0100,
        fn_srlv = 6'b00_0110,
        fn_srav = 6'b00_0111,
        fn_jr   = 6'b00_1000,
        fn_jalr = 6'b00_1001,
        fn_add  = 6'b10_0000,
        fn_addu = 6'b10_0001,
        fn_sub  = 6'b10_0010,
        fn_subu = 6'b10_0011,
        fn_and  = 6'b10_0100,
        fn_or   = 6'b10_0101,
        fn_xor  = 6'b10_0110,
        fn_nor  = 6'b10_0111,
        fn_slt  = 6'b10_1010,
        fn_sltu = 6'b10_1011
    } funct_t;

    // ************************************************************
    // instruction formats
    // ************************************************************
    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [4:0] sa;
        funct_t    funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_t     opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] index;
    } j_fmt_t;

    // one fetched word, read as whichever format the opcode implies
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } inst_t;

endpackage

//--- hdl/operand_bypass.sv
module operand_bypass (
    input  isa_pkg::reg_addr_t  raddr1,
    input  isa_pkg::reg_addr_t  raddr2,
    input  isa_pkg::word_t      rf_rdata1,
    input  isa_pkg::word_t      rf_rdata2,
    input  pipe_pkg::rf_write_t ex_fwd,
    input  pipe_pkg::rf_write_t mem_fwd,
    output isa_pkg::word_t      rs_data,
    output isa_pkg::word_t      rt_data
);

    // youngest producer wins, $0 is never forwarded
    function automatic isa_pkg::word_t pick(
        input isa_pkg::reg_addr_t  addr,
        input isa_pkg::word_t      rf_data,
        input pipe_pkg::rf_write_t ex,
        input pipe_pkg::rf_write_t mem
    );
        logic nonzero;
        nonzero = (addr != '0);
        if (nonzero && ex.we && (ex.waddr == addr)) begin
            return ex.wdata;
        end else if (nonzero && mem.we && (mem.waddr == addr)) begin
            return mem.wdata;
        end
        return rf_data;
    endfunction

    assign rs_data = pick(raddr1, rf_rdata1, ex_fwd, mem_fwd);
    assign rt_data = pick(raddr2, rf_rdata2, ex_fwd, mem_fwd);

endmodule

//--- hdl/pipe_pkg.sv
package pipe_pkg;

    // stall bus, one bit per stage
    typedef logic [5:0] stall_t;

    localparam int stall_if = 1;
    localparam int stall_id = 2;

    typedef struct packed {
        logic           ce;
        isa_pkg::word_t pc;
    } if_to_id_t;

    // shared by write-back and the forwarding paths
    typedef struct packed {
        logic               we;
        isa_pkg::reg_addr_t waddr;
        isa_pkg::word_t     wdata;
    } rf_write_t;

    // ************************************************************
    // control fields for EX
    // ************************************************************
    typedef struct packed {
        logic op_add;
        logic op_sub;
        logic op_slt;
        logic op_sltu;
        logic op_and;
        logic op_nor;
        logic op_or;
        logic op_xor;
        logic op_sll;
        logic op_srl;
        logic op_sra;
        logic op_lui;
    } alu_op_t;

    typedef struct packed {
        logic sa;
        logic rs;
    } src1_sel_t;

    typedef struct packed {
        logic imm_zext;
        logic imm_sext;
        logic rt;
    } src2_sel_t;

    typedef enum logic [1:0] {
        res_alu  = 2'd0,
        res_load = 2'd1,
        res_link = 2'd2
    } res_sel_t;

    typedef struct packed {
        logic beq;
        logic bne;
        logic j;
        logic jal;
        logic jr;
        logic jalr;
    } br_kind_t;

    typedef struct packed {
        isa_pkg::word_t     pc;
        isa_pkg::inst_t     inst;
        alu_op_t            alu_op;
        src1_sel_t          src1_sel;
        src2_sel_t          src2_sel;
        logic               mem_en;
        logic [3:0]         mem_wen;
        logic               rf_we;
        isa_pkg::reg_addr_t rf_waddr;
        res_sel_t           res_sel;
        isa_pkg::word_t     rs_data;
        isa_pkg::word_t     rt_data;
    } id_to_ex_t;

    typedef struct packed {
        logic           taken;
        isa_pkg::word_t target;
    } br_t;

endpackage

//--- hdl/regfile.sv
module regfile (
    input  logic                clk,
    input  logic                rst,
    input  isa_pkg::reg_addr_t  raddr1,
    input  isa_pkg::reg_addr_t  raddr2,
    output isa_pkg::word_t      rdata1,
    output isa_pkg::word_t      rdata2,
    input  pipe_pkg::rf_write_t wr
);

    // $0 has no storage
    isa_pkg::word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wr.we && (wr.waddr != '0)) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    // reads are not bypassed from the port being written
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- sources.f
+incdir+dv
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/if_id_reg.sv
hdl/regfile.sv
hdl/operand_bypass.sv
hdl/inst_decoder.sv
hdl/branch_unit.sv
hdl/id_stage.sv
dv/id_stage_tb.sv
